/* mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// general exception vector with BEV set
`define EXC_VECTOR 32'hbfc0_0380

// status comes out of reset in error level
`define CP0_STATUS_INIT 32'h0000_0004

// config is read only, only the M bit is set
`define CP0_CONFIG_INIT 32'h8000_0000

// writable status fields inside the written word
`define STATUS_IM_HI   15
`define STATUS_IM_LO   8
`define STATUS_ERL_BIT 2
`define STATUS_EXL_BIT 1
`define STATUS_IE_BIT  0

// software interrupt bits inside a cause write
`define CAUSE_SW_IP_HI 9
`define CAUSE_SW_IP_LO 8

`endif

/* mips_pkg.sv */
package mips_pkg;

    // one machine word
    typedef logic [31:0] word_t;

    // cause.exccode values, MIPS32 encoding
    typedef enum logic [4:0] {
        exc_int     = 5'd0,
        exc_adel    = 5'd4,
        exc_ades    = 5'd5,
        exc_syscall = 5'd8,
        exc_brk     = 5'd9,
        exc_ri      = 5'd10,
        exc_ov      = 5'd12
    } exc_code_e;

    // cp0 register numbers (select 0 only)
    typedef enum logic [4:0] {
        cp0_badvaddr = 5'd8,
        cp0_count    = 5'd9,
        cp0_compare  = 5'd11,
        cp0_status   = 5'd12,
        cp0_cause    = 5'd13,
        cp0_epc      = 5'd14,
        cp0_config   = 5'd16
    } cp0_addr_e;

    // status, only IM / ERL / EXL / IE are implemented
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  IM;
        logic [4:0]  rsvd_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } status_t;

    // cause, IP[7] is the timer, IP[1:0] are software interrupts
    typedef struct packed {
        logic        BD;
        logic [14:0] rsvd_hi;
        logic [7:0]  IP;
        logic        rsvd_mid;
        exc_code_e   exccode;
        logic [1:0]  rsvd_lo;
    } cause_t;

    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;
    } cp0_regs_t;

    typedef struct packed {
        logic      wen;
        cp0_addr_e addr;
        word_t     wd;
    } cp0_write_t;

    // synchronous causes raised along the pipeline
    typedef struct packed {
        logic adel_if;
        logic ri;
        logic ov;
        logic syscall;
        logic brk;
        logic adel_data;
        logic ades;
    } exc_flags_t;

    typedef struct packed {
        word_t      pc;
        logic       in_delay_slot;
        exc_flags_t flags;
        word_t      data_addr;
        logic       is_eret;
        cp0_write_t cwrite;
    } commit_t;

    // trap as applied by cp0
    typedef struct packed {
        logic      valid;
        exc_code_e code;
        word_t     pc;
        logic      in_delay_slot;
        word_t     badvaddr;
    } exception_t;

endpackage

/* cp0.sv */
`include "mips_config.svh"

module cp0 (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::exception_t exc,
    input  mips_pkg::cp0_write_t cwrite,
    input  logic                 is_eret,
    input  mips_pkg::cp0_addr_e  raddr,
    output mips_pkg::word_t      rdata,
    output mips_pkg::cp0_regs_t  regs
);
    import mips_pkg::*;

    cp0_regs_t cp0_q;
    cp0_regs_t cp0_d;
    logic      count_phase;
    logic      timer_hit;

    // count ticks at half the core clock
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_phase <= 1'b0;
        end else begin
            count_phase <= ~count_phase;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cp0_q         <= '0;
            cp0_q.status  <= `CP0_STATUS_INIT;
            cp0_q.config_ <= `CP0_CONFIG_INIT;
        end else begin
            cp0_q <= cp0_d;
        end
    end

    assign timer_hit = (cp0_q.count == cp0_q.compare);

    // next state of the register file
    always_comb begin
        cp0_d = cp0_q;

        // free running counter
        if (count_phase) begin
            cp0_d.count = cp0_q.count + 32'd1;
        end

        // timer interrupt is sticky until compare is written
        if (timer_hit) begin
            cp0_d.cause.IP[7] = 1'b1;
        end

        // software writes, later ones win over count and timer
        if (cwrite.wen) begin
            case (cwrite.addr)
                cp0_count: begin
                    cp0_d.count = cwrite.wd;
                end
                cp0_compare: begin
                    cp0_d.compare     = cwrite.wd;
                    cp0_d.cause.IP[7] = 1'b0;
                end
                cp0_status: begin
                    cp0_d.status.IM  = cwrite.wd[`STATUS_IM_HI:`STATUS_IM_LO];
                    cp0_d.status.EXL = cwrite.wd[`STATUS_EXL_BIT];
                    cp0_d.status.IE  = cwrite.wd[`STATUS_IE_BIT];
                end
                cp0_cause: begin
                    cp0_d.cause.IP[1:0] = cwrite.wd[`CAUSE_SW_IP_HI:`CAUSE_SW_IP_LO];
                end
                cp0_epc: begin
                    cp0_d.epc = cwrite.wd;
                end
                // badvaddr and config are read only
                default: begin
                end
            endcase
        end

        // trap entry
        if (exc.valid) begin
            // epc and BD only saved on the first level
            if (!cp0_q.status.EXL) begin
                if (exc.in_delay_slot) begin
                    cp0_d.cause.BD = 1'b1;
                    cp0_d.epc      = exc.pc - 32'd4;
                end else begin
                    cp0_d.cause.BD = 1'b0;
                    cp0_d.epc      = exc.pc;
                end
            end

            cp0_d.cause.exccode = exc.code;
            cp0_d.status.EXL    = 1'b1;

            // address errors, fetch or data
            if (exc.code == exc_adel || exc.code == exc_ades) begin
                cp0_d.badvaddr = exc.badvaddr;
            end
        end

        // return from exception
        if (is_eret) begin
            if (cp0_q.status.ERL) begin
                cp0_d.status.ERL = 1'b0;
            end else begin
                cp0_d.status.EXL = 1'b0;
            end
        end
    end

    // read port
    always_comb begin
        case (raddr)
            cp0_badvaddr: rdata = cp0_q.badvaddr;
            cp0_count:    rdata = cp0_q.count;
            cp0_compare:  rdata = cp0_q.compare;
            cp0_status:   rdata = cp0_q.status;
            cp0_cause:    rdata = cp0_q.cause;
            cp0_epc:      rdata = cp0_q.epc;
            cp0_config:   rdata = cp0_q.config_;
            default:      rdata = '0;
        endcase
    end

    assign regs = cp0_q;

endmodule

/* exception_unit.sv */
`include "mips_config.svh"

module exception_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 commit_valid,
    output logic                 commit_ready,
    input  mips_pkg::commit_t    commit,
    input  mips_pkg::cp0_regs_t  regs,
    output mips_pkg::exception_t exc,
    output mips_pkg::cp0_write_t cwrite,
    output logic                 is_eret,
    output logic                 redirect_valid,
    input  logic                 redirect_ready,
    output mips_pkg::word_t      redirect_pc
);
    import mips_pkg::*;

    logic      fire;
    logic      int_pending;
    logic      trap;
    exc_code_e trap_code;
    word_t     trap_badvaddr;
    logic      take_redirect;

    // stall the pipeline while a redirect waits for fetch
    assign commit_ready = ~redirect_valid;
    assign fire         = commit_valid & commit_ready;

    // enabled interrupt, outside exception and error level
    assign int_pending = regs.status.IE
                       & ~regs.status.EXL
                       & ~regs.status.ERL
                       & (|(regs.cause.IP & regs.status.IM));

    // priority select, interrupt first
    always_comb begin
        trap          = 1'b1;
        trap_code     = exc_int;
        trap_badvaddr = '0;
        if (int_pending) begin
            trap_code = exc_int;
        end else if (commit.flags.adel_if) begin
            trap_code     = exc_adel;
            trap_badvaddr = commit.pc;
        end else if (commit.flags.ri) begin
            trap_code = exc_ri;
        end else if (commit.flags.ov) begin
            trap_code = exc_ov;
        end else if (commit.flags.syscall) begin
            trap_code = exc_syscall;
        end else if (commit.flags.brk) begin
            trap_code = exc_brk;
        end else if (commit.flags.adel_data) begin
            trap_code     = exc_adel;
            trap_badvaddr = commit.data_addr;
        end else if (commit.flags.ades) begin
            trap_code     = exc_ades;
            trap_badvaddr = commit.data_addr;
        end else begin
            trap = 1'b0;
        end
    end

    // trap record toward cp0
    always_comb begin
        exc.valid         = fire & trap;
        exc.code          = trap_code;
        exc.pc            = commit.pc;
        exc.in_delay_slot = commit.in_delay_slot;
        exc.badvaddr      = trap_badvaddr;
    end

    // a trapping instruction does not retire its side effects
    always_comb begin
        cwrite.wen  = fire & ~trap & commit.cwrite.wen;
        cwrite.addr = commit.cwrite.addr;
        cwrite.wd   = commit.cwrite.wd;
    end

    assign is_eret = fire & ~trap & commit.is_eret;

    assign take_redirect = fire & (trap | commit.is_eret);

    // one pending redirect at most
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else if (take_redirect) begin
            redirect_valid <= 1'b1;
        end else if (redirect_ready) begin
            redirect_valid <= 1'b0;
        end
    end

    // target is the vector on a trap, else the epc seen at commit
    always_ff @(posedge clk) begin
        if (take_redirect) begin
            redirect_pc <= trap ? `EXC_VECTOR : regs.epc;
        end
    end

endmodule

/* cp0_unit.sv */
module cp0_unit (
    input  logic                clk,
    input  logic                reset,

    // commit stream from the pipeline
    input  logic                commit_valid,
    output logic                commit_ready,
    input  mips_pkg::commit_t   commit,

    // fetch redirect
    output logic                redirect_valid,
    input  logic                redirect_ready,
    output mips_pkg::word_t     redirect_pc,

    // register read port
    input  mips_pkg::cp0_addr_e raddr,
    output mips_pkg::word_t     rdata
);
    import mips_pkg::*;

    exception_t exc;
    cp0_write_t cwrite;
    logic       is_eret;
    cp0_regs_t  regs;

    exception_unit i_exception_unit (
        .clk            (clk),
        .reset          (reset),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit         (commit),
        .regs           (regs),
        .exc            (exc),
        .cwrite         (cwrite),
        .is_eret        (is_eret),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect_pc    (redirect_pc)
    );

    cp0 i_cp0 (
        .clk     (clk),
        .reset   (reset),
        .exc     (exc),
        .cwrite  (cwrite),
        .is_eret (is_eret),
        .raddr   (raddr),
        .rdata   (rdata),
        .regs    (regs)
    );

endmodule

/* cp0_unit_tb.sv */
`include "mips_config.svh"

module cp0_unit_tb;
    import mips_pkg::*;

    localparam int wait_limit = 50;

    logic       clk;
    logic       reset;
    logic       commit_valid;
    logic       commit_ready;
    commit_t    commit;
    logic       redirect_valid;
    logic       redirect_ready;
    word_t      redirect_pc;
    cp0_addr_e  raddr;
    word_t      rdata;

    int         check_errors;
    int         timeouts;
    word_t      first_rand;
    word_t      saved_epc;

    cp0_unit i_cp0_unit (
        .clk            (clk),
        .reset          (reset),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect_pc    (redirect_pc),
        .raddr          (raddr),
        .rdata          (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic status_t status_value(input logic [7:0] im, input logic erl,
                                             input logic exl, input logic ie);
        status_t s;
        s     = '0;
        s.IM  = im;
        s.ERL = erl;
        s.EXL = exl;
        s.IE  = ie;
        return s;
    endfunction

    function automatic cause_t cause_value(input logic bd, input logic [7:0] ip,
                                           input exc_code_e code);
        cause_t c;
        c         = '0;
        c.BD      = bd;
        c.IP      = ip;
        c.exccode = code;
        return c;
    endfunction

    // word aligned pc in kseg0 and never below 4
    function automatic word_t random_pc();
        return ($urandom & 32'h0fff_fffc) | 32'h8000_0000;
    endfunction

    function automatic commit_t write_record(input word_t pc, input cp0_addr_e addr,
                                             input word_t wd);
        commit_t r;
        r            = '0;
        r.pc         = pc;
        r.cwrite.wen = 1'b1;
        r.cwrite.addr = addr;
        r.cwrite.wd  = wd;
        return r;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cause(input cause_t got, input cause_t exp, input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic commit_one(input commit_t rec);
        int waited;
        waited       = 0;
        commit       = rec;
        commit_valid = 1'b1;
        while (!commit_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!commit_ready) begin
            timeouts++;
            $display("timeout at %0t: commit_ready never came back", $time);
        end
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic accept_redirect(input int hold, input word_t exp_pc);
        int    waited;
        word_t held_pc;
        waited = 0;
        while (!redirect_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!redirect_valid) begin
            timeouts++;
            $display("timeout at %0t: no redirect was raised", $time);
        end else begin
            check_word(redirect_pc, exp_pc, "redirect_pc");
            check_flag(commit_ready, 1'b0, "commit_ready with redirect pending");
            held_pc = redirect_pc;
            repeat (hold) begin
                @(negedge clk);
                check_word(redirect_pc, held_pc, "redirect_pc while stalled");
                check_flag(commit_ready, 1'b0, "commit_ready while stalled");
            end
            redirect_ready = 1'b1;
            @(negedge clk);
            redirect_ready = 1'b0;
            check_flag(redirect_valid, 1'b0, "redirect_valid after accept");
            check_flag(commit_ready, 1'b1, "commit_ready after accept");
        end
    endtask

    task automatic read_reg(input cp0_addr_e addr, output word_t value);
        raddr = addr;
        @(negedge clk);
        value = rdata;
    endtask

    task automatic take_trap(input commit_t rec, input cause_t exp, input string what);
        word_t v;
        commit_one(rec);
        check_flag(redirect_valid, 1'b1, "redirect in the cycle after the trap");
        accept_redirect(0, `EXC_VECTOR);
        read_reg(cp0_cause, v);
        check_cause(cause_t'(v), exp, what);
    endtask

    task automatic reset_and_writes();
        word_t v;
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b1, 1'b0, 1'b0), "status after reset");
        // moving compare far away also drops the reset time IP7
        commit_one(write_record(random_pc(), cp0_compare, 32'hffff_0000));
        read_reg(cp0_compare, v);
        check_word(v, 32'hffff_0000, "compare write");
        read_reg(cp0_cause, v);
        check_cause(cause_t'(v), cause_value(1'b0, 8'h00, exc_int), "cause after compare");
        commit_one(write_record(random_pc(), cp0_epc, 32'h1234_5678));
        read_reg(cp0_epc, v);
        check_word(v, 32'h1234_5678, "epc write");
        commit_one(write_record(random_pc(), cp0_status, 32'hffff_ffff));
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'hff, 1'b1, 1'b1, 1'b1), "status mask");
        commit_one(write_record(random_pc(), cp0_cause, 32'hffff_ffff));
        read_reg(cp0_cause, v);
        check_cause(cause_t'(v), cause_value(1'b0, 8'h03, exc_int), "cause software ip");
        commit_one(write_record(random_pc(), cp0_cause, 32'h0));
        commit_one(write_record(random_pc(), cp0_status, 32'h0));
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b1, 1'b0, 1'b0), "status cleared");
        commit_one(write_record(random_pc(), cp0_badvaddr, 32'hdead_beef));
        read_reg(cp0_badvaddr, v);
        check_word(v, 32'h0, "badvaddr is read only");
        commit_one(write_record(random_pc(), cp0_config, 32'h0000_1234));
        read_reg(cp0_config, v);
        check_word(v, `CP0_CONFIG_INIT, "config is read only");
    endtask

    task automatic syscall_trap();
        word_t   v;
        word_t   pc;
        commit_t rec;
        pc  = random_pc();
        rec = write_record(pc, cp0_compare, 32'h5555_0000);
        rec.flags.syscall = 1'b1;
        take_trap(rec, cause_value(1'b0, 8'h00, exc_syscall), "cause after syscall");
        read_reg(cp0_epc, v);
        check_word(v, pc, "epc after syscall");
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b1, 1'b1, 1'b0), "EXL after syscall");
        read_reg(cp0_compare, v);
        check_word(v, 32'hffff_0000, "trapping write suppressed");
        commit_one(write_record(random_pc(), cp0_status, 32'h0));
        // delay slot case
        pc  = random_pc();
        rec = write_record(pc, cp0_compare, 32'h5555_0000);
        rec.in_delay_slot = 1'b1;
        rec.flags.syscall = 1'b1;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_syscall), "cause in delay slot");
        read_reg(cp0_epc, v);
        check_word(v, pc - 32'd4, "epc in delay slot");
        saved_epc = pc - 32'd4;
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b1, 1'b1, 1'b0), "EXL in delay slot");
        read_reg(cp0_compare, v);
        check_word(v, 32'hffff_0000, "trapping write suppressed in delay slot");
    endtask

    task automatic nested_trap();
        word_t   v;
        commit_t rec;
        rec = '0;
        rec.pc = random_pc();
        rec.flags.ri      = 1'b1;
        rec.flags.ov      = 1'b1;
        rec.flags.syscall = 1'b1;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_ri), "ri over ov and syscall");
        rec.flags = '0;
        rec.flags.ov   = 1'b1;
        rec.flags.brk  = 1'b1;
        rec.flags.ades = 1'b1;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_ov), "ov over brk and ades");
        rec.flags = '0;
        rec.flags.adel_data = 1'b1;
        rec.flags.ades      = 1'b1;
        rec.data_addr       = 32'h0000_1001;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_adel), "adel_data over ades");
        read_reg(cp0_badvaddr, v);
        check_word(v, 32'h0000_1001, "badvaddr for adel_data");
        rec.flags = '0;
        rec.flags.ades = 1'b1;
        rec.data_addr  = 32'h0000_2002;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_ades), "ades");
        read_reg(cp0_badvaddr, v);
        check_word(v, 32'h0000_2002, "badvaddr for ades");
        rec.flags = '0;
        rec.flags.adel_if = 1'b1;
        rec.flags.ades    = 1'b1;
        rec.pc            = 32'h8000_0102;
        take_trap(rec, cause_value(1'b1, 8'h00, exc_adel), "adel_if over ades");
        read_reg(cp0_badvaddr, v);
        check_word(v, 32'h8000_0102, "badvaddr for adel_if");
        read_reg(cp0_epc, v);
        check_word(v, saved_epc, "epc kept while EXL set");
    endtask

    task automatic eret_return();
        word_t   v;
        commit_t rec;
        commit_one(write_record(random_pc(), cp0_epc, 32'h8000_0400));
        rec = '0;
        rec.pc      = random_pc();
        rec.is_eret = 1'b1;
        // first eret since reset leaves error level
        commit_one(rec);
        accept_redirect(0, 32'h8000_0400);
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b0, 1'b1, 1'b0), "ERL cleared");
        commit_one(rec);
        accept_redirect(0, 32'h8000_0400);
        read_reg(cp0_status, v);
        check_status(status_t'(v), status_value(8'h00, 1'b0, 1'b0, 1'b0), "EXL cleared");
    endtask

    task automatic back_pressure();
        word_t   v;
        word_t   pc;
        commit_t rec;
        pc  = random_pc();
        rec = '0;
        rec.pc = pc;
        rec.flags.syscall = 1'b1;
        commit_one(rec);
        // offer a write while fetch has not taken the redirect
        rec = write_record(random_pc(), cp0_epc, 32'h8000_0800);
        commit       = rec;
        commit_valid = 1'b1;
        read_reg(cp0_epc, v);
        read_reg(cp0_epc, v);
        check_word(v, pc, "no commit while stalled");
        accept_redirect(3, `EXC_VECTOR);
        commit_one(rec);
        read_reg(cp0_epc, v);
        check_word(v, 32'h8000_0800, "commit after stall");
        commit_one(write_record(random_pc(), cp0_status, 32'h0));
    endtask

    task automatic interrupts();
        word_t   v;
        word_t   pc;
        commit_t rec;
        int      n;
        commit_one(write_record(random_pc(), cp0_status, 32'h0000_0101));
        commit_one(write_record(random_pc(), cp0_cause, 32'h0000_0100));
        pc  = random_pc();
        rec = write_record(pc, cp0_compare, 32'h0000_0000);
        take_trap(rec, cause_value(1'b0, 8'h01, exc_int), "software interrupt");
        read_reg(cp0_epc, v);
        check_word(v, pc, "epc on interrupt");
        commit_one(write_record(random_pc(), cp0_cause, 32'h0));
        commit_one(write_record(random_pc(), cp0_status, 32'h0000_8001));
        read_reg(cp0_count, v);
        commit_one(write_record(random_pc(), cp0_compare, v + 32'd16));
        // plain commits until the timer fires
        n  = 0;
        pc = random_pc();
        while (!redirect_valid && n < 200) begin
            commit_one(write_record(pc, cp0_badvaddr, 32'h0));
            pc = pc + 32'd4;
            n++;
        end
        if (!redirect_valid) begin
            timeouts++;
            $display("timeout at %0t: timer interrupt never taken", $time);
        end else begin
            accept_redirect(0, `EXC_VECTOR);
            read_reg(cp0_cause, v);
            check_cause(cause_t'(v), cause_value(1'b0, 8'h80, exc_int), "timer interrupt");
        end
        commit_one(write_record(random_pc(), cp0_compare, 32'hffff_0000));
        read_reg(cp0_cause, v);
        check_cause(cause_t'(v), cause_value(1'b0, 8'h00, exc_int), "IP7 cleared by compare");
    endtask

    initial begin
        check_errors   = 0;
        timeouts       = 0;
        first_rand     = $urandom(32'hc808);
        reset          = 1'b1;
        commit_valid   = 1'b0;
        commit         = '0;
        redirect_ready = 1'b0;
        raddr          = cp0_status;
        saved_epc      = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_and_writes();
        syscall_trap();
        nested_trap();
        eret_return();
        back_pressure();
        interrupts();

        $display("errors: %0d check failures, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* cp0_unit.f */
+incdir+.
mips_pkg.sv
cp0.sv
exception_unit.sv
cp0_unit.sv
cp0_unit_tb.sv

/* Bender.yml */
package:
  name: cp0_unit

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - cp0.sv
      - exception_unit.sv
      - cp0_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - cp0_unit_tb.sv
